// ==== verilog/alu_pkg.sv ====
package alu_pkg;

	// data path width
	parameter int XLEN = 32;

	// architectural register count, register 0 reads as zero
	parameter int NREG = 32;

	typedef logic [XLEN-1:0] word_t;

	// register tag
	typedef logic [$clog2(NREG)-1:0] preg_t;

	// wrap bit on top of a 4 bit index
	typedef logic [4:0] age_t;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_SLL,
		OP_SRL
	} alu_op_t;

	// register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		preg_t      rs2;
		preg_t      rs1;
		logic [2:0] funct3;
		preg_t      rd;
		logic [6:0] opcode;
	} insn_r_t;

	// register-immediate layout
	typedef struct packed {
		logic [11:0] imm;
		preg_t       rs1;
		logic [2:0]  funct3;
		preg_t       rd;
		logic [6:0]  opcode;
	} insn_i_t;

	// same 32 bit word seen both ways
	typedef union packed {
		insn_r_t r;
		insn_i_t i;
	} insn_t;

	// one issue queue slot as written by decode
	typedef struct packed {
		alu_op_t op;
		logic    use_imm;
		word_t   imm;
		preg_t   dst;
		age_t    age;
		preg_t   src1;
		logic    src1_ready;
		preg_t   src2;
		logic    src2_ready;
	} iq_entry_t;

endpackage

// ==== verilog/alu_ifs.sv ====
`timescale 1ns/1ps

// decode to issue queue, one beat per accepted instruction
interface iq_write_if;
	logic               valid;
	alu_pkg::iq_entry_t entry;

	modport sender (
		output valid,
		output entry
	);

	modport receiver (
		input valid,
		input entry
	);
endinterface

// issue queue to execute, driven from the chosen slot
interface issue_if;
	logic             valid;
	alu_pkg::alu_op_t op;
	logic             use_imm;
	alu_pkg::word_t   imm;
	alu_pkg::preg_t   dst;
	alu_pkg::preg_t   src1;
	alu_pkg::preg_t   src2;

	modport sender (
		output valid, op, use_imm, imm, dst, src1, src2
	);

	modport receiver (
		input valid, op, use_imm, imm, dst, src1, src2
	);
endinterface

// ==== verilog/alu_decode.sv ====
`timescale 1ns/1ps

module alu_decode (
	input  logic            clk,
	input  logic            reset,
	input  logic            in_valid,
	input  alu_pkg::word_t  in_insn,
	input  logic            full,
	input  logic            wake_valid,
	input  alu_pkg::preg_t  wake_preg,
	output logic            illegal,
	iq_write_if.sender      wr
);
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	alu_pkg::insn_t   insn;
	alu_pkg::alu_op_t op;
	logic             legal;
	logic             is_imm;
	logic             accept;
	alu_pkg::preg_t   src2;
	logic [alu_pkg::NREG-1:0] busy;
	alu_pkg::age_t    age_ptr;

	// ready if never busy or woken this very cycle
	function automatic logic src_ready(alu_pkg::preg_t p);
		return (p == '0) || !busy[p] || (wake_valid && wake_preg == p);
	endfunction

	assign insn = in_insn;

	always_comb begin
		legal = 1'b0;
		is_imm = 1'b0;
		op = alu_pkg::OP_ADD;
		case (insn.r.opcode)
			OPC_OP: begin
				// funct7 zero, or 0100000 only for sub
				legal = (insn.r.funct7 == 7'b0) ||
					(insn.r.funct7 == 7'b0100000 && insn.r.funct3 == 3'b000);
				case (insn.r.funct3)
					3'b000: op = insn.r.funct7[5] ? alu_pkg::OP_SUB : alu_pkg::OP_ADD;
					3'b001: op = alu_pkg::OP_SLL;
					3'b010: op = alu_pkg::OP_SLT;
					3'b100: op = alu_pkg::OP_XOR;
					3'b101: op = alu_pkg::OP_SRL;
					3'b110: op = alu_pkg::OP_OR;
					3'b111: op = alu_pkg::OP_AND;
					// sltu not supported
					default: legal = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				is_imm = 1'b1;
				legal = 1'b1;
				case (insn.i.funct3)
					3'b000: op = alu_pkg::OP_ADD;
					3'b010: op = alu_pkg::OP_SLT;
					3'b100: op = alu_pkg::OP_XOR;
					3'b110: op = alu_pkg::OP_OR;
					3'b111: op = alu_pkg::OP_AND;
					3'b001: begin
						op = alu_pkg::OP_SLL;
						legal = (insn.i.imm[11:5] == 7'b0);
					end
					3'b101: begin
						// srai has bit 10 set, rejected here
						op = alu_pkg::OP_SRL;
						legal = (insn.i.imm[11:5] == 7'b0);
					end
					default: legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase
	end

	assign illegal = in_valid && !legal;
	// dropped silently when the queue has no free slot
	assign accept = in_valid && legal && !full;
	// immediate forms read register 0 as second source
	assign src2 = is_imm ? '0 : insn.r.rs2;

	assign wr.valid = accept;
	assign wr.entry.op = op;
	assign wr.entry.use_imm = is_imm;
	assign wr.entry.imm = is_imm ?
		{{(alu_pkg::XLEN-12){insn.i.imm[11]}}, insn.i.imm} : '0;
	assign wr.entry.dst = insn.r.rd;
	assign wr.entry.age = age_ptr;
	assign wr.entry.src1 = insn.r.rs1;
	assign wr.entry.src1_ready = src_ready(insn.r.rs1);
	assign wr.entry.src2 = src2;
	assign wr.entry.src2_ready = src_ready(src2);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
			age_ptr <= '0;
		end else begin
			// clear first so a new producer of the same reg wins
			if (wake_valid)
				busy[wake_preg] <= 1'b0;
			if (accept && insn.r.rd != '0)
				busy[insn.r.rd] <= 1'b1;
			if (accept)
				age_ptr <= age_ptr + 1'b1;
		end
	end
endmodule

// ==== verilog/alu_iqueue.sv ====
`timescale 1ns/1ps

module alu_iqueue #(
	parameter int QLEN = 8
) (
	input  logic           clk,
	input  logic           reset,
	iq_write_if.receiver   wr,
	input  logic           wake_valid,
	input  alu_pkg::preg_t wake_preg,
	issue_if.sender        iss,
	output logic           full
);
	// QLEN is taken as a power of two
	localparam int LVL = $clog2(QLEN);

	// slot payload
	alu_pkg::alu_op_t op_q [QLEN];
	logic             imm_sel [QLEN];
	alu_pkg::word_t   imm_q [QLEN];
	alu_pkg::preg_t   dst_q [QLEN];
	alu_pkg::age_t    age_q [QLEN];
	alu_pkg::preg_t   s1_q [QLEN];
	alu_pkg::preg_t   s2_q [QLEN];

	// slot control
	logic [QLEN-1:0] v, v_nxt;
	logic [QLEN-1:0] r1, r1_nxt;
	logic [QLEN-1:0] r2, r2_nxt;

	logic [LVL-1:0] fl;
	logic [LVL-1:0] chosen;

	// select tree, level 0 is the slots themselves
	logic           sel_v [LVL+1][QLEN];
	logic [LVL-1:0] sel_id [LVL+1][QLEN];
	alu_pkg::age_t  sel_age [LVL+1][QLEN];

	// wrap bit flips the sense of the index compare
	function automatic logic is_older(logic va, alu_pkg::age_t aa, logic vb, alu_pkg::age_t ab);
		if (va && vb)
			return (aa[$bits(alu_pkg::age_t)-1] == ab[$bits(alu_pkg::age_t)-1]) ^
				(aa[$bits(alu_pkg::age_t)-2:0] > ab[$bits(alu_pkg::age_t)-2:0]);
		return va;
	endfunction

	// lowest free slot, last hit in the loop wins
	always_comb begin
		fl = '0;
		for (int i = QLEN - 1; i >= 0; i--) begin
			if (!v[i])
				fl = LVL'(i);
		end
	end

	assign full = &v;

	for (genvar i = 0; i < QLEN; i++) begin : g_leaf
		assign sel_v[0][i] = v[i] && r1[i] && r2[i];
		assign sel_id[0][i] = LVL'(i);
		assign sel_age[0][i] = age_q[i];
	end

	for (genvar l = 0; l < LVL; l++) begin : g_lvl
		for (genvar j = 0; j < (QLEN >> l); j += 2) begin : g_node
			logic pick_a;
			assign pick_a = is_older(sel_v[l][j], sel_age[l][j],
				sel_v[l][j+1], sel_age[l][j+1]);
			assign sel_v[l+1][j>>1] = pick_a ? sel_v[l][j] : sel_v[l][j+1];
			assign sel_id[l+1][j>>1] = pick_a ? sel_id[l][j] : sel_id[l][j+1];
			assign sel_age[l+1][j>>1] = pick_a ? sel_age[l][j] : sel_age[l][j+1];
		end
	end

	assign chosen = sel_id[LVL][0];

	// chosen slot straight onto the issue port
	assign iss.valid = sel_v[LVL][0];
	assign iss.op = op_q[chosen];
	assign iss.use_imm = imm_sel[chosen];
	assign iss.imm = imm_q[chosen];
	assign iss.dst = dst_q[chosen];
	assign iss.src1 = s1_q[chosen];
	assign iss.src2 = s2_q[chosen];

	always_comb begin
		v_nxt = v;
		r1_nxt = r1;
		r2_nxt = r2;
		// wake against stored tags
		for (int i = 0; i < QLEN; i++) begin
			if (wake_valid && s1_q[i] == wake_preg)
				r1_nxt[i] = 1'b1;
			if (wake_valid && s2_q[i] == wake_preg)
				r2_nxt[i] = 1'b1;
		end
		// new slot, decode already folded in this cycle's wake
		if (wr.valid) begin
			v_nxt[fl] = 1'b1;
			r1_nxt[fl] = wr.entry.src1_ready;
			r2_nxt[fl] = wr.entry.src2_ready;
		end
		// free on issue
		if (iss.valid)
			v_nxt[chosen] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			v <= '0;
			r1 <= '0;
			r2 <= '0;
		end else begin
			v <= v_nxt;
			r1 <= r1_nxt;
			r2 <= r2_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (wr.valid) begin
			op_q[fl] <= wr.entry.op;
			imm_sel[fl] <= wr.entry.use_imm;
			imm_q[fl] <= wr.entry.imm;
			dst_q[fl] <= wr.entry.dst;
			age_q[fl] <= wr.entry.age;
			s1_q[fl] <= wr.entry.src1;
			s2_q[fl] <= wr.entry.src2;
		end
	end
endmodule

// ==== verilog/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
	input  logic            clk,
	input  logic            reset,
	issue_if.receiver       iss,
	output alu_pkg::preg_t  rs1_preg,
	output alu_pkg::preg_t  rs2_preg,
	input  alu_pkg::word_t  rs1_data,
	input  alu_pkg::word_t  rs2_data,
	output logic            res_valid,
	output alu_pkg::preg_t  res_dst,
	output alu_pkg::word_t  res_data
);
	// issue register
	logic             valid_q;
	alu_pkg::alu_op_t op_q;
	logic             use_imm_q;
	alu_pkg::word_t   imm_q;
	alu_pkg::preg_t   dst_q;
	alu_pkg::preg_t   src1_q;
	alu_pkg::preg_t   src2_q;

	alu_pkg::word_t   opa;
	alu_pkg::word_t   opb;

	// no stall, capture every edge
	always_ff @(posedge clk) begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= iss.valid;
	end

	always_ff @(posedge clk) begin
		op_q <= iss.op;
		use_imm_q <= iss.use_imm;
		imm_q <= iss.imm;
		dst_q <= iss.dst;
		src1_q <= iss.src1;
		src2_q <= iss.src2;
	end

	// register file read tags
	assign rs1_preg = src1_q;
	assign rs2_preg = src2_q;

	assign opa = rs1_data;
	assign opb = use_imm_q ? imm_q : rs2_data;

	always_comb begin
		case (op_q)
			alu_pkg::OP_ADD: res_data = opa + opb;
			alu_pkg::OP_SUB: res_data = opa - opb;
			alu_pkg::OP_AND: res_data = opa & opb;
			alu_pkg::OP_OR:  res_data = opa | opb;
			alu_pkg::OP_XOR: res_data = opa ^ opb;
			// signed compare
			alu_pkg::OP_SLT: res_data = alu_pkg::word_t'($signed(opa) < $signed(opb));
			// shift amount is low 5 bits
			alu_pkg::OP_SLL: res_data = opa << opb[4:0];
			alu_pkg::OP_SRL: res_data = opa >> opb[4:0];
			default:         res_data = '0;
		endcase
	end

	assign res_valid = valid_q;
	assign res_dst = dst_q;
endmodule

// ==== verilog/alu_result.sv ====
`timescale 1ns/1ps

module alu_result (
	input  logic            clk,
	input  logic            reset,
	input  alu_pkg::preg_t  rs1_preg,
	input  alu_pkg::preg_t  rs2_preg,
	output alu_pkg::word_t  rs1_data,
	output alu_pkg::word_t  rs2_data,
	input  logic            res_valid,
	input  alu_pkg::preg_t  res_dst,
	input  alu_pkg::word_t  res_data,
	output logic            out_valid,
	output alu_pkg::preg_t  out_dst,
	output alu_pkg::word_t  out_data,
	output logic            wake_valid,
	output alu_pkg::preg_t  wake_preg
);
	alu_pkg::word_t regs [alu_pkg::NREG];

	// register 0 stays at its reset value
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < alu_pkg::NREG; i++)
				regs[i] <= '0;
		end else if (res_valid && res_dst != '0) begin
			regs[res_dst] <= res_data;
		end
	end

	// asynchronous read for the execute stage
	assign rs1_data = regs[rs1_preg];
	assign rs2_data = regs[rs2_preg];

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= res_valid;
	end

	always_ff @(posedge clk) begin
		out_dst <= res_dst;
		out_data <= res_data;
	end

	// wake mirrors the output beat, same cycle
	assign wake_valid = out_valid;
	assign wake_preg = out_dst;
endmodule

// ==== verilog/alu_backend.sv ====
`timescale 1ns/1ps

module alu_backend #(
	parameter int QLEN = 8
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            in_valid,
	input  alu_pkg::word_t  in_insn,
	output logic            full,
	output logic            illegal,
	output logic            out_valid,
	output alu_pkg::preg_t  out_dst,
	output alu_pkg::word_t  out_data
);
	iq_write_if wr_bus ();
	issue_if    iss_bus ();

	// wake bus from result
	logic           wake_valid;
	alu_pkg::preg_t wake_preg;

	// execute to register file and result stage
	alu_pkg::preg_t rs1_preg;
	alu_pkg::preg_t rs2_preg;
	alu_pkg::word_t rs1_data;
	alu_pkg::word_t rs2_data;
	logic           res_valid;
	alu_pkg::preg_t res_dst;
	alu_pkg::word_t res_data;

	alu_decode u_decode (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_insn    (in_insn),
		.full       (full),
		.wake_valid (wake_valid),
		.wake_preg  (wake_preg),
		.illegal    (illegal),
		.wr         (wr_bus.sender)
	);

	alu_iqueue #(
		.QLEN (QLEN)
	) u_iqueue (
		.clk        (clk),
		.reset      (reset),
		.wr         (wr_bus.receiver),
		.wake_valid (wake_valid),
		.wake_preg  (wake_preg),
		.iss        (iss_bus.sender),
		.full       (full)
	);

	alu_execute u_execute (
		.clk       (clk),
		.reset     (reset),
		.iss       (iss_bus.receiver),
		.rs1_preg  (rs1_preg),
		.rs2_preg  (rs2_preg),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.res_valid (res_valid),
		.res_dst   (res_dst),
		.res_data  (res_data)
	);

	alu_result u_result (
		.clk        (clk),
		.reset      (reset),
		.rs1_preg   (rs1_preg),
		.rs2_preg   (rs2_preg),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.res_valid  (res_valid),
		.res_dst    (res_dst),
		.res_data   (res_data),
		.out_valid  (out_valid),
		.out_dst    (out_dst),
		.out_data   (out_data),
		.wake_valid (wake_valid),
		.wake_preg  (wake_preg)
	);
endmodule

// ==== verif/tb_alu_tasks.svh ====
`ifndef TB_ALU_TASKS_SVH
`define TB_ALU_TASKS_SVH

// fibonacci lfsr with taps 32 22 2 1
function automatic logic lfsr_step();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

// one step per bit taken
function automatic logic [31:0] rand_bits(int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++)
		r = {r[30:0], lfsr_step()};
	return r;
endfunction

// OP opcode 0x33
function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

// OP-IMM opcode 0x13
function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd);
	return {imm, rs1, f3, rd, 7'h13};
endfunction

// rv32i semantics on the register mirror
function automatic logic [31:0] ref_result(logic [31:0] insn);
	logic [31:0] a;
	logic [31:0] b;
	logic        sub;
	a = mirror[insn[19:15]];
	if (insn[6:0] == 7'h13) begin
		b = {{20{insn[31]}}, insn[31:20]};
		sub = 1'b0;
	end else begin
		b = mirror[insn[24:20]];
		sub = insn[30];
	end
	case (insn[14:12])
		3'b000: return sub ? a - b : a + b;
		3'b001: return a << b[4:0];
		3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b100: return a ^ b;
		3'b101: return a >> b[4:0];
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

// one strobe just after the edge
// model updated only if the DUT can take it
task automatic send_insn(input logic [31:0] insn, input logic bad);
	exp_t e;
	@(posedge clk);
	#0.5;
	in_valid = 1'b1;
	in_insn = insn;
	drv_bad = bad;
	drv_accepted = 1'b0;
	if (bad) begin
		n_illegal++;
	end else if (full) begin
		// no free slot so the strobe is lost
		n_dropped++;
	end else begin
		e.dst = insn[11:7];
		e.data = ref_result(insn);
		mirror[e.dst] = e.data;
		exp_q.push_back(e);
		n_accepted++;
		drv_accepted = 1'b1;
		last_strobe_cyc = cyc + 1;
	end
endtask

`endif

// ==== verif/tb_alu_backend.sv ====
`timescale 1ns/1ps

module tb_alu_backend;
	localparam int QLEN = 8;
	// 10 + 20 + 1 + 4 + 13 + 2 instructions over the six tests
	localparam int N_INSN = 50;
	localparam int TIMEOUT = N_INSN * (QLEN + 4) + 200;
	// idle window where a stray result would show
	localparam int QUIET = 8;

	typedef struct packed {
		logic [4:0]  dst;
		logic [31:0] data;
	} exp_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        in_valid;
	logic [31:0] in_insn;
	logic        full;
	logic        illegal;
	logic        out_valid;
	logic [4:0]  out_dst;
	logic [31:0] out_data;

	// stimulus and model state
	logic [31:0] lfsr_state;
	logic [31:0] mirror [32];
	exp_t        exp_q [$];
	logic        drv_bad;
	logic        drv_accepted;
	logic        lat_armed;
	string       test_name;
	int          cyc = 0;
	int          last_strobe_cyc = 0;
	int          n_accepted = 0;
	int          n_completed = 0;
	int          n_dropped = 0;
	int          n_illegal = 0;
	int          err_count = 0;
	int          test_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	// outputs captured mid cycle and checked on the next edge
	logic        obs_valid;
	logic [4:0]  obs_dst;
	logic [31:0] obs_data;
	logic        obs_found;
	exp_t        obs_exp;
	int          obs_lat;
	logic        obs_lat_armed;
	logic        obs_full;
	int          obs_inflight;
	logic        obs_strobe;
	logic        obs_bad;
	logic        obs_illegal;

`include "tb_alu_tasks.svh"

	alu_backend #(
		.QLEN (QLEN)
	) dut (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_insn   (in_insn),
		.full      (full),
		.illegal   (illegal),
		.out_valid (out_valid),
		.out_dst   (out_dst),
		.out_data  (out_data)
	);

	// 4 ns period
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT) begin
			$display("timeout after %0d cycles with %0d results outstanding", cyc, exp_q.size());
			$display("Some tests failed");
			$finish;
		end
	end

	// monitor pops the expected fifo in program order
	always @(negedge clk) begin
		obs_valid = out_valid && !reset;
		obs_dst = out_dst;
		obs_data = out_data;
		obs_found = 1'b0;
		obs_lat = cyc - last_strobe_cyc;
		obs_lat_armed = lat_armed;
		if (obs_valid) begin
			n_completed++;
			if (exp_q.size() != 0) begin
				obs_found = 1'b1;
				obs_exp = exp_q.pop_front();
			end
		end
		obs_full = full;
		obs_inflight = n_accepted - n_completed;
		// strobe still on the bus has not reached the queue yet
		if (in_valid && drv_accepted)
			obs_inflight--;
		obs_strobe = in_valid;
		obs_bad = drv_bad;
		obs_illegal = illegal;
	end

	function automatic void count_error();
		err_count++;
		test_errs++;
	endfunction

	a_known: assert property (@(posedge clk) disable iff (reset) obs_valid |-> obs_found)
		else begin
			$display("%s: result for x%0d with no instruction outstanding", test_name, obs_dst);
			count_error();
		end

	a_dst: assert property (@(posedge clk) disable iff (reset)
			obs_valid && obs_found |-> obs_dst == obs_exp.dst)
		else begin
			$display("ERR %s dst expected %0d actual %0d", test_name, obs_exp.dst, obs_dst);
			count_error();
		end

	a_data: assert property (@(posedge clk) disable iff (reset)
			obs_valid && obs_found |-> obs_data == obs_exp.data)
		else begin
			$display("ERR %s x%0d data expected %h actual %h", test_name, obs_dst,
				obs_exp.data, obs_data);
			count_error();
		end

	// strobe edge to out_valid
	a_latency: assert property (@(posedge clk) disable iff (reset)
			obs_valid && obs_lat_armed |-> obs_lat == 2)
		else begin
			$display("ERR %s latency expected 2 actual %0d", test_name, obs_lat);
			count_error();
		end

	a_full: assert property (@(posedge clk) disable iff (reset) obs_inflight < QLEN |-> !obs_full)
		else begin
			$display("%s: full is high with only %0d in flight", test_name, obs_inflight);
			count_error();
		end

	a_illegal: assert property (@(posedge clk) disable iff (reset)
			obs_illegal == (obs_strobe && obs_bad))
		else begin
			$display("ERR %s illegal expected %0b actual %0b", test_name,
				obs_strobe && obs_bad, obs_illegal);
			count_error();
		end

	task automatic bus_idle();
		@(posedge clk);
		#0.5;
		in_valid = 1'b0;
		drv_bad = 1'b0;
		drv_accepted = 1'b0;
	endtask

	task automatic wait_drain();
		bus_idle();
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		wait_drain();
		repeat (QUIET) @(posedge clk);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, test_errs);
		end
	endtask

	// funct3 of the eight r-type ops
	// sub shares the add funct3
	function automatic logic [2:0] r_funct3(int k);
		case (k)
			0, 1: return 3'b000;
			2: return 3'b111;
			3: return 3'b110;
			4: return 3'b100;
			5: return 3'b010;
			6: return 3'b001;
			default: return 3'b101;
		endcase
	endfunction

	task automatic run_immediates();
		logic [2:0] f3;
		start_test("immediates");
		for (int k = 0; k < 10; k++) begin
			// addi andi ori xori slti
			case (k % 5)
				0: f3 = 3'b000;
				1: f3 = 3'b111;
				2: f3 = 3'b110;
				3: f3 = 3'b100;
				default: f3 = 3'b010;
			endcase
			send_insn(enc_i(12'(rand_bits(12)), 5'd0, f3, 5'(k + 1)), 1'b0);
		end
		end_test();
	endtask

	task automatic run_rtype();
		logic [6:0] f7;
		start_test("rtype");
		for (int round = 0; round < 2; round++) begin
			send_insn(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd1), 1'b0);
			send_insn(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd2), 1'b0);
			for (int k = 0; k < 8; k++) begin
				f7 = (k == 1) ? 7'b0100000 : 7'b0;
				send_insn(enc_r(f7, 5'd2, 5'd1, r_funct3(k), 5'(k + 3)), 1'b0);
			end
			// x1 and x2 are read by queued ops until drained
			wait_drain();
		end
		end_test();
	endtask

	task automatic run_latency();
		start_test("latency");
		lat_armed = 1'b1;
		send_insn(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd5), 1'b0);
		end_test();
		lat_armed = 1'b0;
	endtask

	task automatic run_wakeup();
		start_test("wakeup");
		send_insn(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd25), 1'b0);
		// the second consumer lands in a lower slot than the first
		send_insn(enc_r(7'b0, 5'd25, 5'd25, 3'b000, 5'd26), 1'b0);
		send_insn(enc_r(7'b0100000, 5'd25, 5'd0, 3'b000, 5'd27), 1'b0);
		send_insn(enc_i(12'(rand_bits(12)), 5'd25, 3'b100, 5'd28), 1'b0);
		end_test();
	endtask

	task automatic run_full_drop();
		int drops_before;
		start_test("full_drop");
		drops_before = n_dropped;
		send_insn(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd11), 1'b0);
		for (int k = 1; k < 12; k++)
			send_insn(enc_i(12'(rand_bits(12)), 5'(10 + k), 3'b000, 5'(11 + k)), 1'b0);
		// queue is full by now
		send_insn(enc_i(12'h5a5, 5'd0, 3'b000, 5'd23), 1'b0);
		wait_drain();
		assert (n_dropped > drops_before)
		else begin
			$display("%s: no strobe was sent while the queue was full", test_name);
			count_error();
		end
		end_test();
	endtask

	task automatic run_illegal();
		start_test("illegal");
		// custom-0 opcode
		send_insn({12'h0ab, 5'd0, 3'b000, 5'd29, 7'b0001011}, 1'b1);
		send_insn(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd30), 1'b0);
		end_test();
	endtask

	initial begin
		in_valid = 1'b0;
		in_insn = '0;
		drv_bad = 1'b0;
		drv_accepted = 1'b0;
		lat_armed = 1'b0;
		reset = 1'b1;
		lfsr_state = 32'h24c8006b;
		test_name = "reset";
		for (int i = 0; i < 32; i++)
			mirror[i] = '0;
		repeat (10) @(posedge clk);
		#0.5;
		reset = 1'b0;

		run_immediates();
		run_rtype();
		run_latency();
		run_wakeup();
		run_full_drop();
		run_illegal();

		$display("tests %0d, failed %0d, errors %0d, dropped %0d, illegal %0d", tests_run,
			tests_failed, err_count, n_dropped, n_illegal);
		if (err_count == 0 && tests_failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end
endmodule

// ==== tb.f ====
+incdir+verif
verilog/alu_pkg.sv
verilog/alu_ifs.sv
verilog/alu_decode.sv
verilog/alu_iqueue.sv
verilog/alu_execute.sv
verilog/alu_result.sv
verilog/alu_backend.sv
verif/tb_alu_backend.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the ALU back end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_alu_backend \
	-f tb.f -o sim_alu > build.log 2>&1 \
	&& ./obj_dir/sim_alu > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
# the log decides
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
